//--- verilog/cp0_pkg.sv
`default_nettype none

// architectural view of the CP0 block: register numbers, codes, bit fields
package cp0_pkg;

    typedef logic [4:0] exc_code_t;

    // register numbers, sel 0 only
    localparam logic [4:0] REG_COUNT   = 5'd9;
    localparam logic [4:0] REG_COMPARE = 5'd11;
    localparam logic [4:0] REG_STATUS  = 5'd12;
    localparam logic [4:0] REG_CAUSE   = 5'd13;
    localparam logic [4:0] REG_EPC     = 5'd14;  // resume address after a trap

    // ExcCode values latched into cause[6:2]
    localparam exc_code_t EXC_INT = 5'h00;  // interrupt
    localparam exc_code_t EXC_SYS = 5'h08;  // syscall
    localparam exc_code_t EXC_BP  = 5'h09;  // break
    localparam exc_code_t EXC_RI  = 5'h0a;  // reserved instruction
    localparam exc_code_t EXC_OV  = 5'h0c;  // arithmetic overflow

    // status bits
    localparam int ST_IE       = 0;   // global interrupt enable
    localparam int ST_EXL      = 1;   // exception level
    localparam int ST_IM_TIMER = 15;  // timer interrupt mask

    // cause bits
    localparam int CA_TIMER = 15;  // timer interrupt pending

endpackage

`default_nettype wire

//--- verilog/cp0_bus_pkg.sv
`default_nettype none

// definitions for the shared CP0 register bus
package cp0_bus_pkg;

    localparam int CP0_DW = 64;  // data width
    localparam int CP0_RW = 5;   // register number width

    // requester index, one bit is enough for two peers
    typedef enum logic {
        REQ_PIPE  = 1'b0,
        REQ_DEBUG = 1'b1
    } req_id_t;

endpackage

`default_nettype wire

//--- verilog/cp0_bus_if.sv
`timescale 1ns/1ns
`default_nettype none

// one requester's path onto the CP0 register bus
// req and the fields stay steady until gnt is seen
interface cp0_bus_if
    import cp0_bus_pkg::*;
();

    logic              req;      // level, held until gnt
    logic              we;       // 1 write, 0 read
    logic [CP0_RW-1:0] regnum;
    logic [CP0_DW-1:0] wr_data;
    logic              gnt;      // single cycle pulse
    logic [CP0_DW-1:0] rd_data;  // valid in the gnt cycle

    modport requester (
        output req,
        output we,
        output regnum,
        output wr_data,
        input  gnt,
        input  rd_data
    );

    modport target (
        input  req,
        input  we,
        input  regnum,
        input  wr_data,
        output gnt,
        output rd_data
    );

endinterface

`default_nettype wire

//--- verilog/cp0_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module cp0_arbiter
    import cp0_bus_pkg::*;
(
    input  logic              clock,
    input  logic              rst_n,
    cp0_bus_if.target         pipe,
    cp0_bus_if.target         dbg,
    output logic              bus_strobe,
    output logic              bus_we,
    output logic [CP0_RW-1:0] bus_regnum,
    output logic [CP0_DW-1:0] bus_wr_data,
    input  logic [CP0_DW-1:0] bus_rd_data
);

    req_id_t last_q;  // who won the previous grant
    req_id_t winner;
    logic    any_req;

    // one requester gets through directly, a tie goes to whoever lost last
    always_comb begin
        any_req = pipe.req | dbg.req;
        if (pipe.req && dbg.req) begin
            winner = (last_q == REQ_PIPE) ? REQ_DEBUG : REQ_PIPE;
        end else if (dbg.req) begin
            winner = REQ_DEBUG;
        end else begin
            winner = REQ_PIPE;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            last_q <= REQ_DEBUG;  // pipeline takes the first tie
        end else if (any_req) begin
            last_q <= winner;
        end
    end

    // merged bus follows the winner
    assign bus_strobe  = any_req;
    assign bus_we      = (winner == REQ_DEBUG) ? dbg.we      : pipe.we;
    assign bus_regnum  = (winner == REQ_DEBUG) ? dbg.regnum  : pipe.regnum;
    assign bus_wr_data = (winner == REQ_DEBUG) ? dbg.wr_data : pipe.wr_data;

    assign pipe.gnt = any_req && (winner == REQ_PIPE);
    assign dbg.gnt  = any_req && (winner == REQ_DEBUG);

    // read data goes back to the granted side only
    assign pipe.rd_data = pipe.gnt ? bus_rd_data : '0;
    assign dbg.rd_data  = dbg.gnt  ? bus_rd_data : '0;

endmodule

`default_nettype wire

//--- verilog/cp0_exc_encoder.sv
`timescale 1ns/1ns
`default_nettype none

// exception flags to ExcCode, exception level masking lives in cp0_regs
module cp0_exc_encoder
    import cp0_pkg::*;
(
    input  logic      overflow,
    input  logic      reserved_inst,
    input  logic      syscall,
    input  logic      break_,
    output logic      exc_valid,
    output exc_code_t exc_code
);

    assign exc_valid = overflow | reserved_inst | syscall | break_;

    // fixed priority, overflow first
    always_comb begin
        if (overflow) begin
            exc_code = EXC_OV;
        end else if (reserved_inst) begin
            exc_code = EXC_RI;
        end else if (syscall) begin
            exc_code = EXC_SYS;
        end else if (break_) begin
            exc_code = EXC_BP;
        end else begin
            exc_code = EXC_INT;  // don't care, exc_valid is low
        end
    end

endmodule

`default_nettype wire

//--- verilog/cp0_timer.sv
`timescale 1ns/1ns
`default_nettype none

module cp0_timer
    import cp0_pkg::*, cp0_bus_pkg::*;
#(
    parameter int COUNT_DIV = 2  // clocks per count step
) (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              bus_strobe,
    input  logic              bus_we,
    input  logic [CP0_RW-1:0] bus_regnum,
    input  logic [CP0_DW-1:0] bus_wr_data,
    output logic [31:0]       count_q,
    output logic [31:0]       compare_q,
    output logic              timer_pending
);

    localparam int PW = (COUNT_DIV > 1) ? $clog2(COUNT_DIV) : 1;

    logic [PW-1:0] presc_q;
    logic          tick;  // count steps at the end of this cycle
    logic          count_wr;
    logic          compare_wr;

    assign tick       = (presc_q == PW'(COUNT_DIV - 1));
    assign count_wr   = bus_strobe && bus_we && (bus_regnum == REG_COUNT);
    assign compare_wr = bus_strobe && bus_we && (bus_regnum == REG_COMPARE);

    // prescaler runs freely, a count write does not restart it
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            presc_q <= '0;
        end else begin
            presc_q <= tick ? '0 : presc_q + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            count_q       <= '0;
            compare_q     <= '0;
            timer_pending <= 1'b0;
        end else begin
            if (count_wr) begin
                count_q <= bus_wr_data[31:0];  // write beats the increment
            end else if (tick) begin
                count_q <= count_q + 32'd1;
            end

            if (compare_wr) begin
                compare_q <= bus_wr_data[31:0];
            end

            // latched until software rewrites compare
            if (compare_wr) begin
                timer_pending <= 1'b0;
            end else if (tick && (count_q == compare_q)) begin
                timer_pending <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/cp0_regs.sv
`timescale 1ns/1ns
`default_nettype none

module cp0_regs
    import cp0_pkg::*, cp0_bus_pkg::*;
#(
    parameter logic [31:0] STATUS_RESET = 32'h00400004
) (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              bus_strobe,
    input  logic              bus_we,
    input  logic [CP0_RW-1:0] bus_regnum,
    input  logic [CP0_DW-1:0] bus_wr_data,
    output logic [CP0_DW-1:0] bus_rd_data,
    input  logic [31:0]       count_q,
    input  logic [31:0]       compare_q,
    input  logic              timer_pending,
    input  logic              exc_valid,
    input  exc_code_t         exc_code,
    input  logic [63:0]       next_pc,
    input  logic              eret,
    output logic [63:0]       epc,
    output logic              taken
);

    logic [31:0] status_q;
    logic [63:0] epc_q;
    exc_code_t   exc_code_q;  // ExcCode field of cause

    logic        exl;
    logic        timer_irq;
    exc_code_t   trap_code;
    logic        status_wr;
    logic        epc_wr;
    logic [31:0] cause;

    assign status_wr = bus_strobe && bus_we && (bus_regnum == REG_STATUS);
    assign epc_wr    = bus_strobe && bus_we && (bus_regnum == REG_EPC);
    // cause is read only from the bus side

    assign exl       = status_q[ST_EXL];
    assign timer_irq = timer_pending & status_q[ST_IM_TIMER] & status_q[ST_IE];

    // trap decision, the only place where EXL masks anything
    assign taken     = !exl && (exc_valid || timer_irq);
    assign trap_code = exc_valid ? exc_code : EXC_INT;  // exceptions beat the timer

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            status_q         <= STATUS_RESET;
            status_q[ST_EXL] <= 1'b0;  // always leave reset at user level
        end else begin
            if (status_wr) begin
                status_q <= bus_wr_data[31:0];
            end
            // trap, then ERET, then the plain write
            if (taken) begin
                status_q[ST_EXL] <= 1'b1;
            end else if (eret) begin
                status_q[ST_EXL] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            epc_q      <= '0;
            exc_code_q <= EXC_INT;
        end else begin
            if (taken) begin
                epc_q      <= next_pc;  // return point of the trapped flow
                exc_code_q <= trap_code;
            end else if (epc_wr) begin
                epc_q <= bus_wr_data;
            end
        end
    end

    assign epc = epc_q;

    // cause layout: pending at 15, ExcCode at 6:2, rest reads zero
    always_comb begin
        cause           = '0;
        cause[CA_TIMER] = timer_pending;
        cause[6:2]      = exc_code_q;
    end

    always_comb begin
        case (bus_regnum)
            REG_COUNT:   bus_rd_data = {32'b0, count_q};
            REG_COMPARE: bus_rd_data = {32'b0, compare_q};
            REG_STATUS:  bus_rd_data = {32'b0, status_q};
            REG_CAUSE:   bus_rd_data = {32'b0, cause};
            REG_EPC:     bus_rd_data = epc_q;
            default:     bus_rd_data = '0;  // unimplemented register
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/cp0_top.sv
`timescale 1ns/1ns
`default_nettype none

module cp0_top
    import cp0_bus_pkg::*;
#(
    parameter logic [31:0] STATUS_RESET = 32'h00400004,
    parameter int          COUNT_DIV    = 2
) (
    input  logic              clock,
    input  logic              rst_n,

    // pipeline mtc0/mfc0 port
    input  logic              pipe_req,
    input  logic              pipe_we,
    input  logic [CP0_RW-1:0] pipe_regnum,
    input  logic [CP0_DW-1:0] pipe_wr_data,
    output logic              pipe_gnt,
    output logic [CP0_DW-1:0] pipe_rd_data,

    // debug port
    input  logic              dbg_req,
    input  logic              dbg_we,
    input  logic [CP0_RW-1:0] dbg_regnum,
    input  logic [CP0_DW-1:0] dbg_wr_data,
    output logic              dbg_gnt,
    output logic [CP0_DW-1:0] dbg_rd_data,

    input  logic [63:0]       next_pc,
    input  logic              eret,
    input  logic              overflow,
    input  logic              reserved_inst,
    input  logic              syscall,
    input  logic              break_,
    output logic [63:0]       epc,
    output logic              taken
);

    cp0_bus_if pipe_bus ();
    cp0_bus_if dbg_bus ();

    // merged register bus behind the arbiter
    logic              bus_strobe;
    logic              bus_we;
    logic [CP0_RW-1:0] bus_regnum;
    logic [CP0_DW-1:0] bus_wr_data;
    logic [CP0_DW-1:0] bus_rd_data;

    logic              exc_valid;
    logic [4:0]        exc_code;  // ExcCode width
    logic [31:0]       count_q;
    logic [31:0]       compare_q;
    logic              timer_pending;

    assign pipe_bus.req     = pipe_req;
    assign pipe_bus.we      = pipe_we;
    assign pipe_bus.regnum  = pipe_regnum;
    assign pipe_bus.wr_data = pipe_wr_data;
    assign pipe_gnt         = pipe_bus.gnt;
    assign pipe_rd_data     = pipe_bus.rd_data;

    assign dbg_bus.req     = dbg_req;
    assign dbg_bus.we      = dbg_we;
    assign dbg_bus.regnum  = dbg_regnum;
    assign dbg_bus.wr_data = dbg_wr_data;
    assign dbg_gnt         = dbg_bus.gnt;
    assign dbg_rd_data     = dbg_bus.rd_data;

    cp0_arbiter u_arbiter (
        .clock       (clock),
        .rst_n       (rst_n),
        .pipe        (pipe_bus.target),
        .dbg         (dbg_bus.target),
        .bus_strobe  (bus_strobe),
        .bus_we      (bus_we),
        .bus_regnum  (bus_regnum),
        .bus_wr_data (bus_wr_data),
        .bus_rd_data (bus_rd_data)
    );

    cp0_exc_encoder u_exc_encoder (
        .overflow      (overflow),
        .reserved_inst (reserved_inst),
        .syscall       (syscall),
        .break_        (break_),
        .exc_valid     (exc_valid),
        .exc_code      (exc_code)
    );

    cp0_timer #(
        .COUNT_DIV (COUNT_DIV)
    ) u_timer (
        .clock         (clock),
        .rst_n         (rst_n),
        .bus_strobe    (bus_strobe),
        .bus_we        (bus_we),
        .bus_regnum    (bus_regnum),
        .bus_wr_data   (bus_wr_data),
        .count_q       (count_q),
        .compare_q     (compare_q),
        .timer_pending (timer_pending)
    );

    cp0_regs #(
        .STATUS_RESET (STATUS_RESET)
    ) u_regs (
        .clock         (clock),
        .rst_n         (rst_n),
        .bus_strobe    (bus_strobe),
        .bus_we        (bus_we),
        .bus_regnum    (bus_regnum),
        .bus_wr_data   (bus_wr_data),
        .bus_rd_data   (bus_rd_data),
        .count_q       (count_q),
        .compare_q     (compare_q),
        .timer_pending (timer_pending),
        .exc_valid     (exc_valid),
        .exc_code      (exc_code),
        .next_pc       (next_pc),
        .eret          (eret),
        .epc           (epc),
        .taken         (taken)
    );

endmodule

`default_nettype wire

//--- verif/cp0_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cp0_tb
    import cp0_pkg::*, cp0_bus_pkg::*;
();

    localparam logic [31:0] STATUS_RESET = 32'h00400004;
    localparam int          COUNT_DIV    = 2;
    localparam int          RAND_CYCLES  = 2000;
    localparam int          CYCLE_LIMIT  = 3000;  // random run plus reset and margin

    logic        clock = 1'b0;
    logic        rst_n;
    logic        pipe_req;
    logic        pipe_we;
    logic [4:0]  pipe_regnum;
    logic [63:0] pipe_wr_data;
    logic        pipe_gnt;
    logic [63:0] pipe_rd_data;
    logic        dbg_req;
    logic        dbg_we;
    logic [4:0]  dbg_regnum;
    logic [63:0] dbg_wr_data;
    logic        dbg_gnt;
    logic [63:0] dbg_rd_data;
    logic [63:0] next_pc;
    logic        eret;
    logic        overflow;
    logic        reserved_inst;
    logic        syscall;
    logic        break_;
    logic [63:0] epc;
    logic        taken;

    // reference model state
    logic        m_last;  // 1 when debug won the last grant
    int          m_presc;
    logic [31:0] m_count;
    logic [31:0] m_compare;
    logic        m_pend;
    logic [31:0] m_status;
    logic [63:0] m_epc;
    logic [4:0]  m_code;

    logic        pipe_seen;  // gnt seen in the last checked cycle
    logic        dbg_seen;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    cp0_top DUT (.*);

    always #2 clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run timed out after %0d cycles without finishing", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic model_reset();
        m_last           = 1'b1;  // pipeline takes the first tie
        m_presc          = 0;
        m_count          = '0;
        m_compare        = '0;
        m_pend           = 1'b0;
        m_status         = STATUS_RESET;
        m_status[ST_EXL] = 1'b0;
        m_epc            = '0;
        m_code           = '0;
        pipe_seen        = 1'b0;
        dbg_seen         = 1'b0;
    endtask

    function automatic logic [63:0] model_read(input logic [4:0] r);
        logic [31:0] cause;
        cause     = '0;
        cause[15] = m_pend;
        cause[6:2] = m_code;
        case (r)
            REG_COUNT:   return {32'b0, m_count};
            REG_COMPARE: return {32'b0, m_compare};
            REG_STATUS:  return {32'b0, m_status};
            REG_CAUSE:   return {32'b0, cause};
            REG_EPC:     return m_epc;
            default:     return '0;
        endcase
    endfunction

    // mostly valid registers, now and then one that does not exist
    function automatic logic [4:0] pick_reg();
        int n;
        n = int'($urandom % 11);
        case (n)
            0, 1:    return REG_COUNT;
            2, 3:    return REG_COMPARE;
            4, 5:    return REG_STATUS;
            6, 7:    return REG_CAUSE;
            8, 9:    return REG_EPC;
            default: return 5'($urandom % 8);
        endcase
    endfunction

    function automatic logic [63:0] pick_data(input logic [4:0] r);
        if (r == REG_COUNT) return 64'($urandom % 32);  // small so compare gets hit
        if (r == REG_COMPARE) return 64'($urandom % 64);
        return {$urandom, $urandom};
    endfunction

    task automatic drive_random();
        if (!pipe_req || pipe_seen) begin
            pipe_req     = ($urandom % 2) == 0;
            pipe_we      = 1'($urandom % 2);
            pipe_regnum  = pick_reg();
            pipe_wr_data = pick_data(pipe_regnum);
        end
        if (!dbg_req || dbg_seen) begin
            dbg_req     = ($urandom % 3) == 0;
            dbg_we      = 1'($urandom % 2);
            dbg_regnum  = pick_reg();
            dbg_wr_data = pick_data(dbg_regnum);
        end
        overflow      = ($urandom % 60) == 0;  // exceptions are rare
        reserved_inst = ($urandom % 60) == 0;
        syscall       = ($urandom % 60) == 0;
        break_        = ($urandom % 60) == 0;
        eret          = ($urandom % 12) == 0;
        next_pc       = {$urandom, $urandom};
    endtask

    // compare this cycle's outputs, then step the model across the edge
    task automatic check_cycle();
        logic        any;
        logic        win;  // 1 for debug
        logic        bwe;
        logic [4:0]  breg;
        logic [63:0] bdata;
        logic        tick;
        logic        trap;
        logic [4:0]  tcode;
        any = pipe_req | dbg_req;
        win = (pipe_req && dbg_req) ? !m_last : dbg_req;
        bwe   = win ? dbg_we : pipe_we;
        breg  = win ? dbg_regnum : pipe_regnum;
        bdata = win ? dbg_wr_data : pipe_wr_data;
        trap = !m_status[ST_EXL] && (overflow || reserved_inst || syscall || break_ ||
               (m_pend && m_status[ST_IM_TIMER] && m_status[ST_IE]));
        if (overflow) tcode = EXC_OV;
        else if (reserved_inst) tcode = EXC_RI;
        else if (syscall) tcode = EXC_SYS;
        else if (break_) tcode = EXC_BP;
        else tcode = EXC_INT;

        check_val("pipe_gnt", 64'(pipe_gnt), 64'(any && !win));
        check_val("dbg_gnt", 64'(dbg_gnt), 64'(any && win));
        if (any && !win && !pipe_we) check_val("pipe_rd_data", pipe_rd_data, model_read(breg));
        if (any && win && !dbg_we) check_val("dbg_rd_data", dbg_rd_data, model_read(breg));
        check_val("taken", 64'(taken), 64'(trap));
        check_val("epc", epc, m_epc);
        pipe_seen = pipe_gnt;
        dbg_seen  = dbg_gnt;

        tick    = (m_presc == COUNT_DIV - 1);
        m_presc = tick ? 0 : m_presc + 1;
        if (any && bwe && breg == REG_COMPARE) m_pend = 1'b0;
        else if (tick && m_count == m_compare) m_pend = 1'b1;  // old count and compare
        if (any && bwe && breg == REG_COUNT) m_count = bdata[31:0];
        else if (tick) m_count = m_count + 32'd1;
        if (any && bwe && breg == REG_COMPARE) m_compare = bdata[31:0];
        if (any && bwe && breg == REG_STATUS) m_status = bdata[31:0];
        if (trap) m_status[ST_EXL] = 1'b1;
        else if (eret) m_status[ST_EXL] = 1'b0;
        if (trap) begin
            m_epc  = next_pc;
            m_code = tcode;
        end else if (any && bwe && breg == REG_EPC) begin
            m_epc = bdata;
        end
        if (any) m_last = win;
    endtask

    initial begin
        void'($urandom(46));
        rst_n         = 1'b0;
        pipe_req      = 1'b0;
        pipe_we       = 1'b0;
        pipe_regnum   = '0;
        pipe_wr_data  = '0;
        dbg_req       = 1'b0;
        dbg_we        = 1'b0;
        dbg_regnum    = '0;
        dbg_wr_data   = '0;
        next_pc       = '0;
        eret          = 1'b0;
        overflow      = 1'b0;
        reserved_inst = 1'b0;
        syscall       = 1'b0;
        break_        = 1'b0;
        repeat (10) @(posedge clock);
        #1;
        rst_n = 1'b1;
        model_reset();
        #1 check_cycle();  // idle, no grants and nothing taken

        // both ports read reset values, pipe wins the tie
        @(posedge clock);
        #1;
        pipe_req    = 1'b1;
        pipe_regnum = REG_STATUS;
        dbg_req     = 1'b1;
        dbg_regnum  = REG_CAUSE;
        #1 check_cycle();
        @(posedge clock);
        #1;
        pipe_req = 1'b0;  // debug still waiting
        #1 check_cycle();
        @(posedge clock);
        #1;
        pipe_req    = 1'b1;
        pipe_regnum = REG_EPC;
        dbg_regnum  = REG_COMPARE;
        #1 check_cycle();

        repeat (RAND_CYCLES) begin
            @(posedge clock);
            #1;
            drive_random();
            #1;
            check_cycle();
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
verilog/cp0_pkg.sv
verilog/cp0_bus_pkg.sv
verilog/cp0_bus_if.sv
verilog/cp0_arbiter.sv
verilog/cp0_exc_encoder.sv
verilog/cp0_timer.sv
verilog/cp0_regs.sv
verilog/cp0_top.sv
verif/cp0_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := cp0_tb
FILELIST   := src.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
